/* rtl/dbg_pkg.sv */
// Debug request manager shared types: host commands, network responses, FSM states, widths
package dbg_pkg;

	// Default host item width
	localparam int DEF_ITEM_W = 32;

	// Default width of one register lane
	localparam int DEF_REG_W = 32;

	// Default number of lanes in a vector register
	localparam int DEF_LANES = 4;

	// Default number of tiles on the network
	localparam int DEF_TILE_COUNT = 4;

	// Host command opcodes, carried in the low 8 bits of a host item
	// The same code travels in the command field of the network message
	typedef enum logic [7:0] {
		DSU_ENABLE     = 8'h01,
		DSU_DISABLE    = 8'h02,
		DSU_RESUME     = 8'h03,
		DSU_READ_S_REG = 8'h04,
		DSU_READ_V_REG = 8'h05
	} host_cmd_e;

	// Response opcodes returned by the remote debug unit
	typedef enum logic [7:0] {
		DSU_ACK_RSP       = 8'h10,
		DSU_REG_VALUE_RSP = 8'h11
	} net_rsp_e;

	// Control FSM states
	typedef enum logic [3:0] {
		// One idle cycle after reset before items are accepted
		START     = 4'd0,
		IDLE      = 4'd1,
		WAIT_DEST = 4'd2,
		WAIT_ADDR = 4'd3,
		BUILD_MSG = 4'd4,
		SEND_NET  = 4'd5,
		// Waiting for the network answer
		WAIT_ACK  = 4'd6,
		WAIT_REG  = 4'd7,
		// Reply words to the host
		SEND_HOST = 4'd8,
		NEXT_LANE = 4'd9
	} req_state_e;

endpackage

/* rtl/dbg_request_fsm.sv */
// Debug request control FSM sequencing host items, network sends and replies to the host
module dbg_request_fsm #(
	parameter int ITEM_W = dbg_pkg::DEF_ITEM_W
) (
	input  logic              clk,
	input  logic              reset,

	// Host input side
	input  logic [ITEM_W-1:0] item_data_i,
	input  logic              item_valid_i,
	output logic              item_avail_o,

	// Host output side
	input  logic              item_avail_i,
	output logic              item_valid_o,

	// Network side
	input  logic              c2n_available_i,
	output logic              c2n_valid_o,
	input  logic              n2c_valid_i,
	input  dbg_pkg::net_rsp_e n2c_rsp_i,
	output logic              n2c_consumed_o,

	// Register block status
	input  dbg_pkg::host_cmd_e cmd_i,
	input  logic              last_lane_i,

	// Register block strobes
	output logic              ld_cmd_o,
	output logic              ld_dest_o,
	output logic              ld_addr_o,
	output logic              ld_msg_o,
	output logic              ld_ack_o,
	output logic              ld_reply_o,
	output logic              shift_reply_o,
	output logic              clr_lane_o
);

	dbg_pkg::req_state_e state;
	dbg_pkg::req_state_e next_state;
	dbg_pkg::host_cmd_e  host_cmd;
	logic                cmd_is_read;

	// Opcode in the low byte of the incoming item
	assign host_cmd = dbg_pkg::host_cmd_e'(item_data_i[7:0]);

	// Stored command selects the awaited response
	assign cmd_is_read = (cmd_i == dbg_pkg::DSU_READ_S_REG) ||
		(cmd_i == dbg_pkg::DSU_READ_V_REG);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= dbg_pkg::START;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state     = state;
		item_avail_o   = 1'b0;
		item_valid_o   = 1'b0;
		c2n_valid_o    = 1'b0;
		n2c_consumed_o = 1'b0;
		ld_cmd_o       = 1'b0;
		ld_dest_o      = 1'b0;
		ld_addr_o      = 1'b0;
		ld_msg_o       = 1'b0;
		ld_ack_o       = 1'b0;
		ld_reply_o     = 1'b0;
		shift_reply_o  = 1'b0;
		clr_lane_o     = 1'b0;

		case (state)
			dbg_pkg::START: begin
				next_state = dbg_pkg::IDLE;
			end

			dbg_pkg::IDLE: begin
				item_avail_o = 1'b1;
				if (item_valid_i) begin
					// Unknown opcodes are dropped and the FSM stays idle
					case (host_cmd)
						dbg_pkg::DSU_ENABLE,
						dbg_pkg::DSU_DISABLE: begin
							ld_cmd_o   = 1'b1;
							clr_lane_o = 1'b1;
							next_state = dbg_pkg::WAIT_DEST;
						end
						dbg_pkg::DSU_READ_S_REG,
						dbg_pkg::DSU_READ_V_REG: begin
							ld_cmd_o   = 1'b1;
							clr_lane_o = 1'b1;
							next_state = dbg_pkg::WAIT_ADDR;
						end
						dbg_pkg::DSU_RESUME: begin
							// Resume keeps the last destination
							ld_cmd_o   = 1'b1;
							clr_lane_o = 1'b1;
							next_state = dbg_pkg::BUILD_MSG;
						end
						default: begin
							next_state = dbg_pkg::IDLE;
						end
					endcase
				end
			end

			dbg_pkg::WAIT_DEST: begin
				item_avail_o = 1'b1;
				if (item_valid_i) begin
					ld_dest_o  = 1'b1;
					next_state = dbg_pkg::BUILD_MSG;
				end
			end

			dbg_pkg::WAIT_ADDR: begin
				item_avail_o = 1'b1;
				if (item_valid_i) begin
					ld_addr_o  = 1'b1;
					next_state = dbg_pkg::BUILD_MSG;
				end
			end

			dbg_pkg::BUILD_MSG: begin
				ld_msg_o   = 1'b1;
				next_state = dbg_pkg::SEND_NET;
			end

			dbg_pkg::SEND_NET: begin
				if (c2n_available_i) begin
					c2n_valid_o = 1'b1;
					next_state  = cmd_is_read ? dbg_pkg::WAIT_REG : dbg_pkg::WAIT_ACK;
				end
			end

			dbg_pkg::WAIT_ACK: begin
				// Other opcodes stay pending in the network
				if (n2c_valid_i && n2c_rsp_i == dbg_pkg::DSU_ACK_RSP) begin
					n2c_consumed_o = 1'b1;
					ld_ack_o       = 1'b1;
					next_state     = dbg_pkg::SEND_HOST;
				end
			end

			dbg_pkg::WAIT_REG: begin
				if (n2c_valid_i && n2c_rsp_i == dbg_pkg::DSU_REG_VALUE_RSP) begin
					n2c_consumed_o = 1'b1;
					ld_reply_o     = 1'b1;
					next_state     = dbg_pkg::SEND_HOST;
				end
			end

			dbg_pkg::SEND_HOST: begin
				if (item_avail_i) begin
					item_valid_o = 1'b1;
					next_state   = last_lane_i ? dbg_pkg::IDLE : dbg_pkg::NEXT_LANE;
				end
			end

			dbg_pkg::NEXT_LANE: begin
				shift_reply_o = 1'b1;
				next_state    = dbg_pkg::SEND_HOST;
			end

			default: begin
				next_state = dbg_pkg::START;
			end
		endcase
	end

endmodule

/* rtl/dbg_message_regs.sv */
// Debug request register block holding command, destination, outgoing message and reply lanes
module dbg_message_regs #(
	parameter int ITEM_W     = dbg_pkg::DEF_ITEM_W,
	parameter int REG_W      = dbg_pkg::DEF_REG_W,
	parameter int LANES      = dbg_pkg::DEF_LANES,
	parameter int TILE_COUNT = dbg_pkg::DEF_TILE_COUNT
) (
	input  logic                   clk,
	input  logic                   reset,

	// Data inputs
	input  logic [ITEM_W-1:0]      item_data_i,
	input  dbg_pkg::net_rsp_e      n2c_rsp_i,
	input  logic [REG_W*LANES-1:0] n2c_data_i,

	// Strobes from the FSM
	input  logic                   ld_cmd_i,
	input  logic                   ld_dest_i,
	input  logic                   ld_addr_i,
	input  logic                   ld_msg_i,
	input  logic                   ld_ack_i,
	input  logic                   ld_reply_i,
	input  logic                   shift_reply_i,
	input  logic                   clr_lane_i,

	// Status to the FSM
	output dbg_pkg::host_cmd_e     cmd_o,
	output logic                   last_lane_o,

	// Host and network data
	output logic [ITEM_W-1:0]      item_data_o,
	output dbg_pkg::host_cmd_e     c2n_cmd_o,
	output logic                   c2n_enable_o,
	output logic [REG_W*LANES-1:0] c2n_data_o,
	output logic [TILE_COUNT-1:0]  c2n_dest_mask_o
);

	localparam int PAY_W  = REG_W * LANES;
	localparam int DEST_W = (TILE_COUNT > 1) ? $clog2(TILE_COUNT) : 1;
	localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;
	localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(LANES - 1);

	dbg_pkg::host_cmd_e cmd_q;
	logic [DEST_W-1:0]  dest_q;
	logic [ITEM_W-1:0]  addr_q;
	logic [PAY_W-1:0]   reply_q;
	logic [PAY_W-1:0]   reply_next;
	logic [LANE_W-1:0]  lane_cnt;

	// Command, destination and lane counter
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			cmd_q    <= dbg_pkg::DSU_RESUME;
			dest_q   <= '0;
			lane_cnt <= '0;
		end else begin
			if (ld_cmd_i) begin
				cmd_q <= dbg_pkg::host_cmd_e'(item_data_i[7:0]);
			end
			if (ld_dest_i) begin
				dest_q <= item_data_i[DEST_W-1:0];
			end
			if (clr_lane_i) begin
				lane_cnt <= '0;
			end else if (shift_reply_i) begin
				lane_cnt <= lane_cnt + 1'b1;
			end
		end
	end

	// Reply after dropping the lane just sent
	assign reply_next = reply_q >> REG_W;

	// Address, outgoing message and host data
	always_ff @(posedge clk) begin
		if (ld_addr_i) begin
			addr_q <= item_data_i;
		end
		if (ld_msg_i) begin
			c2n_cmd_o    <= cmd_q;
			c2n_enable_o <= (cmd_q == dbg_pkg::DSU_ENABLE);
			if (cmd_q == dbg_pkg::DSU_READ_S_REG || cmd_q == dbg_pkg::DSU_READ_V_REG) begin
				// Register address in the low item, rest zero
				c2n_data_o <= PAY_W'(addr_q);
			end else begin
				c2n_data_o <= '1;
			end
		end
		if (ld_ack_i) begin
			item_data_o <= ITEM_W'(n2c_rsp_i);
		end else if (ld_reply_i) begin
			reply_q     <= n2c_data_i;
			item_data_o <= ITEM_W'(n2c_data_i[REG_W-1:0]);
		end else if (shift_reply_i) begin
			reply_q     <= reply_next;
			item_data_o <= ITEM_W'(reply_next[REG_W-1:0]);
		end
	end

	assign cmd_o = cmd_q;

	// Vector reads walk all lanes, everything else returns a single item
	assign last_lane_o = (cmd_q == dbg_pkg::DSU_READ_V_REG) ? (lane_cnt == LAST_LANE) : 1'b1;

	// Destination index to one-hot tile mask
	assign c2n_dest_mask_o = TILE_COUNT'(1) << dest_q;

endmodule

/* rtl/dbg_request_manager.sv */
// Debug request manager top level joining the control FSM and its message register block
module dbg_request_manager #(
	parameter int ITEM_W     = dbg_pkg::DEF_ITEM_W,
	parameter int REG_W      = dbg_pkg::DEF_REG_W,
	parameter int LANES      = dbg_pkg::DEF_LANES,
	parameter int TILE_COUNT = dbg_pkg::DEF_TILE_COUNT
) (
	input  logic                   clk,
	input  logic                   reset,

	// Host input side
	input  logic [ITEM_W-1:0]      item_data_i,
	input  logic                   item_valid_i,
	output logic                   item_avail_o,

	// Host output side
	output logic [ITEM_W-1:0]      item_data_o,
	output logic                   item_valid_o,
	input  logic                   item_avail_i,

	// Network send side
	output logic                   c2n_valid_o,
	input  logic                   c2n_available_i,
	output dbg_pkg::host_cmd_e     c2n_cmd_o,
	output logic                   c2n_enable_o,
	output logic [REG_W*LANES-1:0] c2n_data_o,
	output logic [TILE_COUNT-1:0]  c2n_dest_mask_o,

	// Network receive side
	input  logic                   n2c_valid_i,
	input  dbg_pkg::net_rsp_e      n2c_rsp_i,
	input  logic [REG_W*LANES-1:0] n2c_data_i,
	output logic                   n2c_consumed_o
);

	dbg_pkg::host_cmd_e cmd;
	logic               last_lane;
	logic               ld_cmd;
	logic               ld_dest;
	logic               ld_addr;
	logic               ld_msg;
	logic               ld_ack;
	logic               ld_reply;
	logic               shift_reply;
	logic               clr_lane;

	dbg_request_fsm #(
		.ITEM_W(ITEM_W)
	) u_fsm (
		.clk             (clk),
		.reset           (reset),
		.item_data_i     (item_data_i),
		.item_valid_i    (item_valid_i),
		.item_avail_o    (item_avail_o),
		.item_avail_i    (item_avail_i),
		.item_valid_o    (item_valid_o),
		.c2n_available_i (c2n_available_i),
		.c2n_valid_o     (c2n_valid_o),
		.n2c_valid_i     (n2c_valid_i),
		.n2c_rsp_i       (n2c_rsp_i),
		.n2c_consumed_o  (n2c_consumed_o),
		.cmd_i           (cmd),
		.last_lane_i     (last_lane),
		.ld_cmd_o        (ld_cmd),
		.ld_dest_o       (ld_dest),
		.ld_addr_o       (ld_addr),
		.ld_msg_o        (ld_msg),
		.ld_ack_o        (ld_ack),
		.ld_reply_o      (ld_reply),
		.shift_reply_o   (shift_reply),
		.clr_lane_o      (clr_lane)
	);

	dbg_message_regs #(
		.ITEM_W     (ITEM_W),
		.REG_W      (REG_W),
		.LANES      (LANES),
		.TILE_COUNT (TILE_COUNT)
	) u_regs (
		.clk             (clk),
		.reset           (reset),
		.item_data_i     (item_data_i),
		.n2c_rsp_i       (n2c_rsp_i),
		.n2c_data_i      (n2c_data_i),
		.ld_cmd_i        (ld_cmd),
		.ld_dest_i       (ld_dest),
		.ld_addr_i       (ld_addr),
		.ld_msg_i        (ld_msg),
		.ld_ack_i        (ld_ack),
		.ld_reply_i      (ld_reply),
		.shift_reply_i   (shift_reply),
		.clr_lane_i      (clr_lane),
		.cmd_o           (cmd),
		.last_lane_o     (last_lane),
		.item_data_o     (item_data_o),
		.c2n_cmd_o       (c2n_cmd_o),
		.c2n_enable_o    (c2n_enable_o),
		.c2n_data_o      (c2n_data_o),
		.c2n_dest_mask_o (c2n_dest_mask_o)
	);

endmodule

/* tests/tb_clock.sv */
// Testbench clock source toggling at a fixed period
module tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

endmodule

/* tests/dbg_checker.sv */
// Debug request manager checker comparing network messages and host items with expectations
module dbg_checker #(
	parameter int ITEM_W     = dbg_pkg::DEF_ITEM_W,
	parameter int REG_W      = dbg_pkg::DEF_REG_W,
	parameter int LANES      = dbg_pkg::DEF_LANES,
	parameter int TILE_COUNT = dbg_pkg::DEF_TILE_COUNT
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    item_valid_i,
	input  logic                    item_avail_i,
	input  logic [ITEM_W-1:0]       item_data_i,
	input  logic                    c2n_valid_i,
	input  logic [7:0]              c2n_cmd_i,
	input  logic                    c2n_enable_i,
	input  logic [REG_W*LANES-1:0]  c2n_data_i,
	input  logic [TILE_COUNT-1:0]   c2n_dest_mask_i,
	input  logic                    n2c_consumed_i,
	input  logic [7:0]              n2c_rsp_i,
	input  logic [7:0]              exp_cmd_i,
	input  logic [31:0]             exp_dest_i,
	input  logic [31:0]             exp_addr_i,
	input  logic [7:0]              exp_rsp_i,
	input  logic [31:0]             exp_cnt_i,
	input  logic [LANES*ITEM_W-1:0] exp_words_i,
	input  logic                    test_done_i,
	input  logic                    all_done_i,
	output int                      fail_count_o
);

	localparam int PAY_W = REG_W * LANES;

	int test_num = 1;
	int test_errs = 0;
	int msg_cnt = 0;
	int item_cnt = 0;
	int consume_cnt = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	assign fail_count_o = tests_failed;

	task automatic check_value(input string name, input logic [PAY_W-1:0] got,
		input logic [PAY_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] test %0d %s exp=%0h got=%0h", test_num, name, exp, got);
			test_errs++;
		end
	endtask

	// Message fields follow from the command, destination and address
	task automatic check_message();
		logic                  is_read;
		logic [PAY_W-1:0]      exp_data;
		logic [TILE_COUNT-1:0] exp_mask;
		is_read = (exp_cmd_i == dbg_pkg::DSU_READ_S_REG) ||
			(exp_cmd_i == dbg_pkg::DSU_READ_V_REG);
		exp_data = is_read ? PAY_W'(exp_addr_i) : {PAY_W{1'b1}};
		// Only the destination tile bit is set
		for (int i = 0; i < TILE_COUNT; i++) begin
			exp_mask[i] = (i == int'(exp_dest_i));
		end
		check_value("c2n_cmd_o", PAY_W'(c2n_cmd_i), PAY_W'(exp_cmd_i));
		check_value("c2n_enable_o", PAY_W'(c2n_enable_i),
			PAY_W'(exp_cmd_i == dbg_pkg::DSU_ENABLE));
		check_value("c2n_data_o", c2n_data_i, exp_data);
		check_value("c2n_dest_mask_o", PAY_W'(c2n_dest_mask_i), PAY_W'(exp_mask));
		msg_cnt++;
	endtask

	task automatic check_item();
		if (item_cnt >= int'(exp_cnt_i)) begin
			$display("Test %0d: more host items than the %0d expected", test_num, exp_cnt_i);
			test_errs++;
		end else begin
			check_value("item_data_o", PAY_W'(item_data_i),
				PAY_W'(exp_words_i[item_cnt*ITEM_W +: ITEM_W]));
		end
		item_cnt++;
	endtask

	task automatic close_test();
		if (msg_cnt != 1) begin
			$display("Test %0d: saw %0d network messages instead of one", test_num, msg_cnt);
			test_errs++;
		end
		if (consume_cnt != 1) begin
			$display("Test %0d: saw %0d consume pulses instead of one", test_num, consume_cnt);
			test_errs++;
		end
		if (item_cnt != int'(exp_cnt_i)) begin
			$display("Test %0d: got %0d host items, expected %0d", test_num, item_cnt, exp_cnt_i);
			test_errs++;
		end
		if (test_errs == 0) begin
			$display("Test %0d cmd %02h: passed", test_num, exp_cmd_i);
			tests_passed++;
		end else begin
			$display("Test %0d cmd %02h: failed with %0d errors", test_num, exp_cmd_i, test_errs);
			tests_failed++;
		end
		test_num++;
		test_errs = 0;
		msg_cnt = 0;
		item_cnt = 0;
		consume_cnt = 0;
	endtask

	// Outputs are stable at the rising edge since inputs move on the falling edge
	always @(posedge clk) begin
		if (!reset) begin
			if (c2n_valid_i) begin
				check_message();
			end
			if (item_valid_i && item_avail_i) begin
				check_item();
			end
			if (n2c_consumed_i) begin
				check_value("n2c_rsp_i at consume", PAY_W'(n2c_rsp_i), PAY_W'(exp_rsp_i));
				consume_cnt++;
			end
			if (test_done_i) begin
				close_test();
			end
			if (all_done_i) begin
				$display("Summary: %0d tests, %0d passed, %0d failed",
					tests_passed + tests_failed, tests_passed, tests_failed);
			end
		end
	end

endmodule

/* tests/dbg_assert.sv */
// Handshake assertions for the debug request manager, bound to its top level
module dbg_assert #(
	parameter int TILE_COUNT = dbg_pkg::DEF_TILE_COUNT
) (
	input logic                  clk,
	input logic                  reset,
	input logic                  in_avail_i,
	input logic                  out_valid_i,
	input logic                  out_ready_i,
	input logic                  net_valid_i,
	input logic                  net_avail_i,
	input logic                  consumed_i,
	input logic [TILE_COUNT-1:0] dest_mask_i
);

	net_valid_needs_avail: assert property (@(posedge clk) disable iff (reset)
		net_valid_i |-> net_avail_i)
		else $error("c2n_valid_o raised while c2n_available_i is low");

	host_valid_needs_avail: assert property (@(posedge clk) disable iff (reset)
		out_valid_i |-> out_ready_i)
		else $error("item_valid_o raised while item_avail_i is low");

	dest_mask_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot(dest_mask_i))
		else $error("c2n_dest_mask_o is not one-hot");

	quiet_in_reset: assert property (@(posedge clk)
		reset |-> !(in_avail_i || out_valid_i || net_valid_i || consumed_i))
		else $error("handshake output high during reset");

	// START cycle right after release
	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !(in_avail_i || out_valid_i || net_valid_i || consumed_i))
		else $error("handshake output high in the cycle after reset");

	// IDLE accepts items on the second clock after release
	avail_after_start: assert property (@(posedge clk)
		$fell(reset) |=> in_avail_i)
		else $error("item_avail_o low on the second clock after reset");

endmodule

bind dbg_request_manager dbg_assert #(
	.TILE_COUNT(TILE_COUNT)
) u_assert (
	.clk         (clk),
	.reset       (reset),
	.in_avail_i  (item_avail_o),
	.out_valid_i (item_valid_o),
	.out_ready_i (item_avail_i),
	.net_valid_i (c2n_valid_o),
	.net_avail_i (c2n_available_i),
	.consumed_i  (n2c_consumed_o),
	.dest_mask_i (c2n_dest_mask_o)
);

/* tests/tb_top.sv */
// Debug request manager testbench playing host and remote tile from golden vectors
module tb_top;

	localparam int ITEM_W     = dbg_pkg::DEF_ITEM_W;
	localparam int REG_W      = dbg_pkg::DEF_REG_W;
	localparam int LANES      = dbg_pkg::DEF_LANES;
	localparam int TILE_COUNT = dbg_pkg::DEF_TILE_COUNT;
	localparam int PAY_W      = REG_W * LANES;
	// Words per golden line and the largest test count
	localparam int FIELDS     = 14;
	localparam int MAX_TESTS  = 32;

	logic                    clk;
	logic                    reset;
	logic [ITEM_W-1:0]       item_data_i;
	logic                    item_valid_i;
	logic                    item_avail_o;
	logic [ITEM_W-1:0]       item_data_o;
	logic                    item_valid_o;
	logic                    item_avail_i;
	logic                    c2n_valid_o;
	logic                    c2n_available_i;
	dbg_pkg::host_cmd_e      c2n_cmd_o;
	logic                    c2n_enable_o;
	logic [PAY_W-1:0]        c2n_data_o;
	logic [TILE_COUNT-1:0]   c2n_dest_mask_o;
	logic                    n2c_valid_i;
	dbg_pkg::net_rsp_e       n2c_rsp_i;
	logic [PAY_W-1:0]        n2c_data_i;
	logic                    n2c_consumed_o;

	logic [7:0]              exp_cmd;
	logic [31:0]             exp_dest;
	logic [31:0]             exp_addr;
	logic [7:0]              exp_rsp;
	logic [31:0]             exp_cnt;
	logic [LANES*ITEM_W-1:0] exp_words;
	logic                    test_done;
	logic                    all_done;
	int                      fail_count;
	int                      num_tests = 0;
	logic [31:0]             last_dest;
	logic [31:0]             rng;
	logic [31:0]             golden [0:FIELDS*MAX_TESTS-1];

	tb_clock #(.PERIOD(8)) u_clock (.clk_o(clk));

	dbg_request_manager #(
		.ITEM_W(ITEM_W), .REG_W(REG_W), .LANES(LANES), .TILE_COUNT(TILE_COUNT)
	) dut (
		.clk(clk), .reset(reset),
		.item_data_i(item_data_i), .item_valid_i(item_valid_i), .item_avail_o(item_avail_o),
		.item_data_o(item_data_o), .item_valid_o(item_valid_o), .item_avail_i(item_avail_i),
		.c2n_valid_o(c2n_valid_o), .c2n_available_i(c2n_available_i), .c2n_cmd_o(c2n_cmd_o),
		.c2n_enable_o(c2n_enable_o), .c2n_data_o(c2n_data_o), .c2n_dest_mask_o(c2n_dest_mask_o),
		.n2c_valid_i(n2c_valid_i), .n2c_rsp_i(n2c_rsp_i), .n2c_data_i(n2c_data_i),
		.n2c_consumed_o(n2c_consumed_o)
	);

	dbg_checker #(
		.ITEM_W(ITEM_W), .REG_W(REG_W), .LANES(LANES), .TILE_COUNT(TILE_COUNT)
	) u_checker (
		.clk(clk), .reset(reset),
		.item_valid_i(item_valid_o), .item_avail_i(item_avail_i), .item_data_i(item_data_o),
		.c2n_valid_i(c2n_valid_o), .c2n_cmd_i(c2n_cmd_o), .c2n_enable_i(c2n_enable_o),
		.c2n_data_i(c2n_data_o), .c2n_dest_mask_i(c2n_dest_mask_o),
		.n2c_consumed_i(n2c_consumed_o), .n2c_rsp_i(n2c_rsp_i),
		.exp_cmd_i(exp_cmd), .exp_dest_i(exp_dest), .exp_addr_i(exp_addr), .exp_rsp_i(exp_rsp),
		.exp_cnt_i(exp_cnt), .exp_words_i(exp_words),
		.test_done_i(test_done), .all_done_i(all_done), .fail_count_o(fail_count)
	);

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Host and network back-pressure, each ready three cycles in four
	initial begin
		item_avail_i = 1'b0;
		c2n_available_i = 1'b0;
		rng = 32'd6128;
		forever begin
			@(negedge clk);
			rng = next_rand(rng);
			item_avail_i = (rng[1:0] != 2'b00);
			c2n_available_i = (rng[3:2] != 2'b00);
		end
	end

	task automatic send_item(input logic [ITEM_W-1:0] data);
		@(negedge clk);
		item_data_i = data;
		item_valid_i = 1'b1;
		do @(posedge clk); while (!item_avail_o);
		@(negedge clk);
		item_valid_i = 1'b0;
	endtask

	// Optional decoy with the other opcode first, which must stay pending
	task automatic answer_network(input dbg_pkg::net_rsp_e rsp, input logic decoy,
		input logic [PAY_W-1:0] data);
		@(negedge clk);
		n2c_valid_i = 1'b1;
		if (decoy) begin
			n2c_rsp_i = (rsp == dbg_pkg::DSU_ACK_RSP) ? dbg_pkg::DSU_REG_VALUE_RSP
				: dbg_pkg::DSU_ACK_RSP;
			n2c_data_i = ~data;
			repeat (3) @(negedge clk);
		end
		n2c_rsp_i = rsp;
		n2c_data_i = data;
		do @(posedge clk); while (!n2c_consumed_o);
		@(negedge clk);
		n2c_valid_i = 1'b0;
	endtask

	task automatic collect_items(input int count);
		int n;
		n = 0;
		while (n < count) begin
			@(posedge clk);
			if (item_valid_o && item_avail_i) begin
				n++;
			end
		end
	endtask

	task automatic run_test(input int t);
		int               base;
		logic [7:0]       cmd;
		logic             is_read;
		logic [PAY_W-1:0] data;
		base = t * FIELDS;
		cmd = golden[base][7:0];
		is_read = (cmd == dbg_pkg::DSU_READ_S_REG) || (cmd == dbg_pkg::DSU_READ_V_REG);
		// Resume and reads keep the destination of the last enable or disable
		if (cmd == dbg_pkg::DSU_ENABLE || cmd == dbg_pkg::DSU_DISABLE) begin
			last_dest = golden[base + 1];
		end
		for (int l = 0; l < LANES; l++) begin
			data[l*REG_W +: REG_W] = REG_W'(golden[base + 5 + l]);
			exp_words[l*ITEM_W +: ITEM_W] = ITEM_W'(golden[base + 10 + l]);
		end
		exp_cmd = cmd;
		exp_dest = last_dest;
		exp_addr = golden[base + 2];
		exp_rsp = golden[base + 3][7:0];
		exp_cnt = golden[base + 9];
		send_item(ITEM_W'(golden[base]));
		if (cmd == dbg_pkg::DSU_ENABLE || cmd == dbg_pkg::DSU_DISABLE) begin
			send_item(ITEM_W'(golden[base + 1]));
		end else if (is_read) begin
			send_item(ITEM_W'(golden[base + 2]));
		end
		do @(posedge clk); while (!c2n_valid_o);
		answer_network(dbg_pkg::net_rsp_e'(exp_rsp), golden[base + 4] != 0, data);
		collect_items(int'(exp_cnt));
		do @(posedge clk); while (!item_avail_o);
		@(negedge clk);
		test_done = 1'b1;
		@(negedge clk);
		test_done = 1'b0;
	endtask

	initial begin
		item_data_i = '0;
		item_valid_i = 1'b0;
		n2c_valid_i = 1'b0;
		n2c_rsp_i = dbg_pkg::DSU_ACK_RSP;
		n2c_data_i = '0;
		reset = 1'b1;
		exp_cmd = '0;
		exp_dest = '0;
		exp_addr = '0;
		exp_rsp = '0;
		exp_cnt = '0;
		exp_words = '0;
		test_done = 1'b0;
		all_done = 1'b0;
		last_dest = '0;
		for (int i = 0; i < FIELDS * MAX_TESTS; i++) begin
			golden[i] = '0;
		end
		$readmemh("tests/dbg_golden.txt", golden);
		while (num_tests < MAX_TESTS && golden[num_tests * FIELDS] != 0) begin
			num_tests++;
		end
		if (num_tests == 0) begin
			$display("No tests found in tests/dbg_golden.txt");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			repeat (5) @(posedge clk);
			@(negedge clk);
			reset = 1'b0;
			for (int t = 0; t < num_tests; t++) begin
				run_test(t);
			end
			@(negedge clk);
			all_done = 1'b1;
			@(negedge clk);
			all_done = 1'b0;
			if (fail_count == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

	// Watchdog sized from the test count
	initial begin
		wait (num_tests > 0);
		repeat (num_tests * 200 + 10) @(posedge clk);
		$display("Timeout: DUT stopped responding within %0d cycles", num_tests * 200 + 10);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* tests/dbg_golden.txt */
// cmd dest addr rsp decoy lane0 lane1 lane2 lane3 count exp0 exp1 exp2 exp3 (all hex)
// Lanes are the response data, lowest lane first; decoy sends the other opcode first
01 2 00000000 10 0 00000000 00000000 00000000 00000000 1 00000010 00000000 00000000 00000000
04 0 000001a4 11 0 cafe0001 deadbeef 00000000 00000000 1 cafe0001 00000000 00000000 00000000
05 0 00000200 11 1 11111111 22222222 33333333 44444444 4 11111111 22222222 33333333 44444444
03 0 00000000 10 1 00000000 00000000 00000000 00000000 1 00000010 00000000 00000000 00000000
02 3 00000000 10 0 00000000 00000000 00000000 00000000 1 00000010 00000000 00000000 00000000
03 0 00000000 10 0 00000000 00000000 00000000 00000000 1 00000010 00000000 00000000 00000000
01 1 00000000 10 1 00000000 00000000 00000000 00000000 1 00000010 00000000 00000000 00000000
05 0 00007ff0 11 0 a5a50000 a5a50001 a5a50002 a5a50003 4 a5a50000 a5a50001 a5a50002 a5a50003
04 0 ffffffff 11 1 0bad0c0d 12345678 9abcdef0 0fedcba9 1 0bad0c0d 00000000 00000000 00000000
02 0 00000000 10 0 00000000 00000000 00000000 00000000 1 00000010 00000000 00000000 00000000

/* all.f */
rtl/dbg_pkg.sv
rtl/dbg_request_fsm.sv
rtl/dbg_message_regs.sv
rtl/dbg_request_manager.sv
tests/tb_clock.sv
tests/dbg_checker.sv
tests/dbg_assert.sv
tests/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
